//--- source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	// Widths with a meaning of their own
	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;
	typedef logic [3:0] reg_idx_t;

	// Flag vector, Z on top, then V, then N
	typedef logic [2:0] flags_t;

	localparam int unsigned FLAG_Z = 2;
	localparam int unsigned FLAG_V = 1;
	localparam int unsigned FLAG_N = 0;

	// Write masks for the flag register
	localparam flags_t FLAGS_ALL = 3'b111;
	localparam flags_t FLAGS_Z_ONLY = 3'b100;

	// Major opcode in bits 15:12
	// 0011 and 0111 are unused in this core
	typedef enum logic [3:0] {
		ADD = 4'b0000,
		SUB = 4'b0001,
		XOR = 4'b0010,
		SLL = 4'b0100,
		SRA = 4'b0101,
		ROR = 4'b0110,
		LW  = 4'b1000,
		SW  = 4'b1001,
		LHB = 4'b1010,
		LLB = 4'b1011,
		B   = 4'b1100,
		BR  = 4'b1101,
		PCS = 4'b1110,
		HLT = 4'b1111
	} opcode_t;

	// Branch condition in bits 11:9
	typedef enum logic [2:0] {
		NE     = 3'b000,
		EQ     = 3'b001,
		GT     = 3'b010,
		LT     = 3'b011,
		GE     = 3'b100,
		LE     = 3'b101,
		OVF    = 3'b110,
		ALWAYS = 3'b111
	} cond_t;

endpackage

`default_nettype wire

//--- source/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	// Fetch to decode, valid low marks a bubble
	typedef struct packed {
		logic valid;
		cpu_isa_pkg::instr_t instr;
		cpu_isa_pkg::word_t pc_next;
	} if_id_t;

	// Decode to execute
	typedef struct packed {
		cpu_isa_pkg::word_t pc_next;
		cpu_isa_pkg::instr_t instr;
		cpu_isa_pkg::word_t data_a;
		cpu_isa_pkg::word_t data_b;
		cpu_isa_pkg::reg_idx_t src_a;
		cpu_isa_pkg::reg_idx_t src_b;
		cpu_isa_pkg::reg_idx_t dst;
		logic reg_write;
		logic mem_to_reg;
		logic mem_write;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		cpu_isa_pkg::word_t result;
		cpu_isa_pkg::word_t store_data;
		cpu_isa_pkg::word_t addr;
		cpu_isa_pkg::reg_idx_t dst;
		logic reg_write;
		logic mem_to_reg;
		logic mem_write;
		logic halt;
	} ex_mem_t;

	// Memory to writeback
	typedef struct packed {
		cpu_isa_pkg::word_t wdata;
		cpu_isa_pkg::reg_idx_t dst;
		logic reg_write;
		logic halt;
	} mem_wb_t;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input wire logic clk,
	input wire logic arst_n,
	input wire cpu_isa_pkg::reg_idx_t rd_idx_a,
	input wire cpu_isa_pkg::reg_idx_t rd_idx_b,
	output cpu_isa_pkg::word_t rd_data_a,
	output cpu_isa_pkg::word_t rd_data_b,
	input wire logic wr_en,
	input wire cpu_isa_pkg::reg_idx_t wr_idx,
	input wire cpu_isa_pkg::word_t wr_data
);

	cpu_isa_pkg::word_t regs [16];

	// Register 0 is never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Writeback data bypasses the array on a same-cycle hit
	assign rd_data_a = (rd_idx_a == '0) ? '0 :
		(wr_en && (wr_idx == rd_idx_a)) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 :
		(wr_en && (wr_idx == rd_idx_b)) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire cpu_isa_pkg::opcode_t op,
	input wire cpu_isa_pkg::word_t a,
	input wire cpu_isa_pkg::word_t b,
	output cpu_isa_pkg::word_t result,
	output cpu_isa_pkg::flags_t flags,
	output cpu_isa_pkg::flags_t flag_wen
);

	logic [3:0] shamt;
	logic [31:0] rot;
	logic ovf;

	// Shift amount is the low nibble only
	assign shamt = b[3:0];
	// Rotate via a doubled word
	assign rot = {a, a} >> shamt;

	always_comb begin
		result = '0;
		ovf = 1'b0;
		flag_wen = '0;
		case (op)
			cpu_isa_pkg::ADD: begin
				result = a + b;
				// Operands agree in sign and the result does not
				ovf = (a[15] == b[15]) && (result[15] != a[15]);
				flag_wen = cpu_isa_pkg::FLAGS_ALL;
			end
			cpu_isa_pkg::SUB: begin
				result = a - b;
				ovf = (a[15] != b[15]) && (result[15] != a[15]);
				flag_wen = cpu_isa_pkg::FLAGS_ALL;
			end
			cpu_isa_pkg::XOR: begin
				result = a ^ b;
				flag_wen = cpu_isa_pkg::FLAGS_Z_ONLY;
			end
			cpu_isa_pkg::SLL: begin
				result = a << shamt;
				flag_wen = cpu_isa_pkg::FLAGS_Z_ONLY;
			end
			cpu_isa_pkg::SRA: begin
				result = $signed(a) >>> shamt;
				flag_wen = cpu_isa_pkg::FLAGS_Z_ONLY;
			end
			cpu_isa_pkg::ROR: begin
				result = rot[15:0];
				flag_wen = cpu_isa_pkg::FLAGS_Z_ONLY;
			end
			// Everything else leaves the flags alone
			default: begin
				result = '0;
			end
		endcase
	end

	assign flags[cpu_isa_pkg::FLAG_Z] = (result == '0);
	assign flags[cpu_isa_pkg::FLAG_V] = ovf;
	assign flags[cpu_isa_pkg::FLAG_N] = result[15];

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
	input wire logic clk,
	input wire logic arst_n,
	input wire cpu_isa_pkg::flags_t flags_new,
	input wire cpu_isa_pkg::flags_t flags_wen,
	input wire logic flush,
	input wire cpu_isa_pkg::instr_t instr,
	input wire cpu_isa_pkg::word_t pc_next,
	input wire cpu_isa_pkg::word_t reg_data,
	output logic taken,
	output cpu_isa_pkg::word_t target
);

	cpu_isa_pkg::flags_t flags;
	cpu_isa_pkg::opcode_t op;
	cpu_isa_pkg::cond_t cond;
	cpu_isa_pkg::word_t offset;
	logic z, v, n;
	logic cond_met;

	// Flag register, masked per bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (!flush) begin
			flags <= (flags & ~flags_wen) | (flags_new & flags_wen);
		end
	end

	assign z = flags[cpu_isa_pkg::FLAG_Z];
	assign v = flags[cpu_isa_pkg::FLAG_V];
	assign n = flags[cpu_isa_pkg::FLAG_N];

	assign op = cpu_isa_pkg::opcode_t'(instr[15:12]);
	assign cond = cpu_isa_pkg::cond_t'(instr[11:9]);

	always_comb begin
		case (cond)
			cpu_isa_pkg::NE:     cond_met = !z;
			cpu_isa_pkg::EQ:     cond_met = z;
			cpu_isa_pkg::GT:     cond_met = !z && !n;
			cpu_isa_pkg::LT:     cond_met = n;
			cpu_isa_pkg::GE:     cond_met = z || !n;
			cpu_isa_pkg::LE:     cond_met = z || n;
			cpu_isa_pkg::OVF:    cond_met = v;
			cpu_isa_pkg::ALWAYS: cond_met = 1'b1;
			default:             cond_met = 1'b0;
		endcase
	end

	// Word offset, sign extended and doubled
	assign offset = {{6{instr[8]}}, instr[8:0], 1'b0};

	assign taken = cond_met && ((op == cpu_isa_pkg::B) || (op == cpu_isa_pkg::BR));
	assign target = (op == cpu_isa_pkg::BR) ? reg_data : pc_next + offset;

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input wire logic clk,
	input wire logic arst_n,
	input wire cpu_isa_pkg::reg_idx_t id_src_a,
	input wire cpu_isa_pkg::reg_idx_t id_src_b,
	input wire cpu_isa_pkg::reg_idx_t ex_dst,
	input wire cpu_isa_pkg::reg_idx_t mem_dst,
	input wire cpu_isa_pkg::reg_idx_t wb_dst,
	input wire logic ex_mem_to_reg,
	input wire logic mem_reg_write,
	input wire logic wb_reg_write,
	input wire cpu_isa_pkg::reg_idx_t ex_src_a,
	input wire cpu_isa_pkg::reg_idx_t ex_src_b,
	input wire logic id_is_halt,
	input wire logic wb_halt,
	input wire logic flush,
	output logic stall,
	output logic fetch_hold,
	output logic hlt,
	output cpu_pipe_pkg::fwd_sel_t fwd_a,
	output cpu_pipe_pkg::fwd_sel_t fwd_b
);

	typedef enum logic [1:0] {
		RUNNING,
		DRAINING,
		HALTED
	} halt_state_t;

	halt_state_t state, state_next;
	logic halt_seen;

	// Newest producer wins, R0 never forwards
	function automatic cpu_pipe_pkg::fwd_sel_t pick_source(
		input cpu_isa_pkg::reg_idx_t src,
		input cpu_isa_pkg::reg_idx_t m_dst,
		input logic m_wen,
		input cpu_isa_pkg::reg_idx_t w_dst,
		input logic w_wen
	);
		if (src == '0) begin
			return cpu_pipe_pkg::FWD_NONE;
		end else if (m_wen && (m_dst == src)) begin
			return cpu_pipe_pkg::FWD_MEM;
		end else if (w_wen && (w_dst == src)) begin
			return cpu_pipe_pkg::FWD_WB;
		end
		return cpu_pipe_pkg::FWD_NONE;
	endfunction

	assign fwd_a = pick_source(ex_src_a, mem_dst, mem_reg_write, wb_dst, wb_reg_write);
	assign fwd_b = pick_source(ex_src_b, mem_dst, mem_reg_write, wb_dst, wb_reg_write);

	// Load in EX, consumer in ID
	assign stall = ex_mem_to_reg && (ex_dst != '0) &&
		((id_src_a == ex_dst) || (id_src_b == ex_dst));

	// ---------------------------------------
	// Halt sequencing
	// ---------------------------------------

	// A squashed HLT does not count
	assign halt_seen = id_is_halt && !flush;

	always_comb begin
		state_next = state;
		case (state)
			RUNNING: begin
				if (halt_seen) begin
					state_next = DRAINING;
				end
			end
			DRAINING: begin
				if (wb_halt) begin
					state_next = HALTED;
				end
			end
			HALTED: state_next = HALTED;
			default: state_next = RUNNING;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RUNNING;
		end else begin
			state <= state_next;
		end
	end

	assign fetch_hold = (state != RUNNING) || halt_seen;
	// Up as soon as HLT sits in writeback
	assign hlt = (state == HALTED) || ((state == DRAINING) && wb_halt);

	a_no_stall_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		!(stall && hlt));

endmodule

`default_nettype wire

//--- source/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu #(
	parameter cpu_isa_pkg::word_t reset_vector = 16'h0000
) (
	input wire logic clk,
	input wire logic arst_n,
	output cpu_isa_pkg::word_t imem_addr,
	input wire cpu_isa_pkg::instr_t imem_data,
	output cpu_isa_pkg::word_t dmem_addr,
	output cpu_isa_pkg::word_t dmem_wdata,
	output logic dmem_wen,
	input wire cpu_isa_pkg::word_t dmem_rdata,
	output logic hlt,
	output cpu_isa_pkg::word_t pc_out
);

	// Hazard and branch control
	logic stall, fetch_hold, taken;
	cpu_pipe_pkg::fwd_sel_t fwd_a, fwd_b;
	cpu_isa_pkg::word_t target;

	// Pipeline registers
	cpu_pipe_pkg::if_id_t if_id;
	cpu_pipe_pkg::id_ex_t id_ex, id_ex_next;
	cpu_pipe_pkg::ex_mem_t ex_mem, ex_mem_next;
	cpu_pipe_pkg::mem_wb_t mem_wb;

	// ---------------------------------------
	// Fetch
	// ---------------------------------------
	cpu_isa_pkg::word_t pc, pc_plus_2;

	assign pc_plus_2 = pc + 16'd2;
	assign imem_addr = pc;
	assign pc_out = pc;

	// Branch redirect beats stall and halt hold
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_vector;
		end else if (taken) begin
			pc <= target;
		end else if (!stall && !fetch_hold) begin
			pc <= pc_plus_2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (taken) begin
			if_id <= '0;
		end else if (!stall) begin
			// Bubbles behind a decoded HLT
			if (fetch_hold) begin
				if_id <= '0;
			end else begin
				if_id <= '{valid: 1'b1, instr: imem_data, pc_next: pc_plus_2};
			end
		end
	end

	// ---------------------------------------
	// Decode
	// ---------------------------------------
	cpu_isa_pkg::opcode_t id_op;
	cpu_isa_pkg::reg_idx_t id_src_a, id_src_b;
	cpu_isa_pkg::word_t id_data_a, id_data_b;
	logic id_is_halt;

	assign id_op = cpu_isa_pkg::opcode_t'(if_id.instr[15:12]);
	assign id_is_halt = if_id.valid && (id_op == cpu_isa_pkg::HLT);

	// Unused sources read R0, so they never stall or forward
	always_comb begin
		id_src_a = if_id.instr[7:4];
		id_src_b = '0;
		case (id_op)
			cpu_isa_pkg::ADD, cpu_isa_pkg::SUB, cpu_isa_pkg::XOR: id_src_b = if_id.instr[3:0];
			cpu_isa_pkg::SLL, cpu_isa_pkg::SRA, cpu_isa_pkg::ROR: id_src_b = '0;
			cpu_isa_pkg::LW, cpu_isa_pkg::BR: id_src_b = '0;
			// Store data comes from the rt field
			cpu_isa_pkg::SW: id_src_b = if_id.instr[11:8];
			// Byte loads merge into their own destination
			cpu_isa_pkg::LHB, cpu_isa_pkg::LLB: id_src_a = if_id.instr[11:8];
			default: id_src_a = '0;
		endcase
		if (!if_id.valid) begin
			id_src_a = '0;
			id_src_b = '0;
		end
	end

	register_file u_register_file (
		.clk(clk),
		.arst_n(arst_n),
		.rd_idx_a(id_src_a),
		.rd_idx_b(id_src_b),
		.rd_data_a(id_data_a),
		.rd_data_b(id_data_b),
		.wr_en(mem_wb.reg_write),
		.wr_idx(mem_wb.dst),
		.wr_data(mem_wb.wdata)
	);

	always_comb begin
		id_ex_next.pc_next = if_id.pc_next;
		id_ex_next.instr = if_id.instr;
		id_ex_next.data_a = id_data_a;
		id_ex_next.data_b = id_data_b;
		id_ex_next.src_a = id_src_a;
		id_ex_next.src_b = id_src_b;
		id_ex_next.dst = if_id.instr[11:8];
		id_ex_next.reg_write = if_id.valid && (id_op inside {cpu_isa_pkg::ADD,
			cpu_isa_pkg::SUB, cpu_isa_pkg::XOR, cpu_isa_pkg::SLL, cpu_isa_pkg::SRA,
			cpu_isa_pkg::ROR, cpu_isa_pkg::LW, cpu_isa_pkg::LHB, cpu_isa_pkg::LLB,
			cpu_isa_pkg::PCS});
		id_ex_next.mem_to_reg = if_id.valid && (id_op == cpu_isa_pkg::LW);
		id_ex_next.mem_write = if_id.valid && (id_op == cpu_isa_pkg::SW);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (taken || stall) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

	// ---------------------------------------
	// Execute
	// ---------------------------------------
	cpu_isa_pkg::opcode_t ex_op;
	cpu_isa_pkg::word_t ex_a, ex_b, alu_b, alu_result, mem_data;
	cpu_isa_pkg::flags_t alu_flags, alu_flag_wen, ex_flag_wen;

	function automatic cpu_isa_pkg::word_t fwd_mux(
		input cpu_pipe_pkg::fwd_sel_t sel,
		input cpu_isa_pkg::word_t reg_val,
		input cpu_isa_pkg::word_t mem_val,
		input cpu_isa_pkg::word_t wb_val
	);
		case (sel)
			cpu_pipe_pkg::FWD_MEM: return mem_val;
			cpu_pipe_pkg::FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign ex_op = cpu_isa_pkg::opcode_t'(id_ex.instr[15:12]);
	assign ex_a = fwd_mux(fwd_a, id_ex.data_a, mem_data, mem_wb.wdata);
	assign ex_b = fwd_mux(fwd_b, id_ex.data_b, mem_data, mem_wb.wdata);

	// Shifts take the immediate nibble
	assign alu_b = (ex_op inside {cpu_isa_pkg::SLL, cpu_isa_pkg::SRA, cpu_isa_pkg::ROR}) ?
		{12'b0, id_ex.instr[3:0]} : ex_b;

	alu u_alu (
		.op(ex_op),
		.a(ex_a),
		.b(alu_b),
		.result(alu_result),
		.flags(alu_flags),
		.flag_wen(alu_flag_wen)
	);

	// Bubbles carry instr zero, keep them off the flags
	assign ex_flag_wen = id_ex.reg_write ? alu_flag_wen : '0;

	branch_unit u_branch_unit (
		.clk(clk),
		.arst_n(arst_n),
		.flags_new(alu_flags),
		.flags_wen(ex_flag_wen),
		.flush(taken),
		.instr(id_ex.instr),
		.pc_next(id_ex.pc_next),
		.reg_data(ex_a),
		.taken(taken),
		.target(target)
	);

	always_comb begin
		ex_mem_next.store_data = ex_b;
		// Halfword-aligned base plus doubled offset
		ex_mem_next.addr = (ex_a & 16'hFFFE) +
			{{11{id_ex.instr[3]}}, id_ex.instr[3:0], 1'b0};
		ex_mem_next.dst = id_ex.dst;
		ex_mem_next.reg_write = id_ex.reg_write;
		ex_mem_next.mem_to_reg = id_ex.mem_to_reg;
		ex_mem_next.mem_write = id_ex.mem_write;
		ex_mem_next.halt = (ex_op == cpu_isa_pkg::HLT);
		case (ex_op)
			cpu_isa_pkg::LHB: ex_mem_next.result = {id_ex.instr[7:0], ex_a[7:0]};
			cpu_isa_pkg::LLB: ex_mem_next.result = {ex_a[15:8], id_ex.instr[7:0]};
			cpu_isa_pkg::PCS: ex_mem_next.result = id_ex.pc_next;
			default: ex_mem_next.result = alu_result;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= ex_mem_next;
		end
	end

	// ---------------------------------------
	// Memory and writeback
	// ---------------------------------------
	assign dmem_addr = ex_mem.addr;
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_wen = ex_mem.mem_write;
	assign mem_data = ex_mem.mem_to_reg ? dmem_rdata : ex_mem.result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= '{wdata: mem_data, dst: ex_mem.dst,
				reg_write: ex_mem.reg_write, halt: ex_mem.halt};
		end
	end

	hazard_unit u_hazard_unit (
		.clk(clk),
		.arst_n(arst_n),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.ex_dst(id_ex.dst),
		.mem_dst(ex_mem.dst),
		.wb_dst(mem_wb.dst),
		.ex_mem_to_reg(id_ex.mem_to_reg),
		.mem_reg_write(ex_mem.reg_write),
		.wb_reg_write(mem_wb.reg_write),
		.ex_src_a(id_ex.src_a),
		.ex_src_b(id_ex.src_b),
		.id_is_halt(id_is_halt),
		.wb_halt(mem_wb.halt),
		.flush(taken),
		.stall(stall),
		.fetch_hold(fetch_hold),
		.hlt(hlt),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	// Nothing younger than HLT may reach memory
	a_no_store_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		hlt |-> !dmem_wen);

endmodule

`default_nettype wire

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Program image for the reset vector at byte address 0x0020
// R15 holds the store base of 0x0010 and later 0x0020
localparam cpu_isa_pkg::instr_t program_words [51] = '{
	// Store base, two loads, add with a load-use stall, sub
	16'hBF10, 16'h8100, 16'h8201, 16'h0312, 16'h93F0, 16'h1412, 16'h94F1,
	// Build 0xFFF0 and 0x0020 then add and sub across the 16-bit boundary
	16'hB5F0, 16'hA5FF, 16'hB620, 16'h0756, 16'h1876, 16'h97F2, 16'h98F3,
	// Dependent chain through MEM and WB forwarding
	16'h0912, 16'h0991, 16'h1992, 16'h2A93, 16'h9AF4,
	// Load, then SLL by 3, SRA by 5, ROR by 7
	16'h8B02, 16'h4CB3, 16'h5DB5, 16'h6EB7, 16'h9CF5, 16'h9DF6, 16'h9EF7,
	// Second store base, PCS, LHB then LLB on a loaded word
	16'hBF20, 16'hE100, 16'h91F0, 16'hA212, 16'h92F1, 16'hB234, 16'h92F2,
	// Zero from SUB, B EQ over two stores, B NE falls through
	16'h1322, 16'hC202, 16'h92F7, 16'h92F6, 16'hC001, 16'h93F3,
	// BR to 0x007A skips two stores and an HLT
	16'hB47A, 16'hA400, 16'hDE40, 16'h92F5, 16'h92F4, 16'hF000,
	// Store, load it back with a stall, HLT, then a store that never runs
	16'h94F5, 16'h85F5, 16'h0655, 16'h96F6, 16'hF000, 16'h96F7
};

// Fetch freezes on the word after the final HLT
localparam cpu_isa_pkg::word_t halt_pc = 16'h0084;

// Stores in program order from the loaded data words
task automatic load_expected();
	cpu_isa_pkg::word_t d0;
	cpu_isa_pkg::word_t d1;
	cpu_isa_pkg::word_t d2;
	d0 = dmem[0];
	d1 = dmem[1];
	d2 = dmem[2];
	expect_store("add of two loads", 16'h0010, d0 + d1);
	expect_store("sub of two loads", 16'h0012, d0 - d1);
	expect_store("add wraparound", 16'h0014, 16'h0010);
	expect_store("sub wraparound", 16'h0016, 16'hFFF0);
	expect_store("forwarding chain", 16'h0018, (d0 + d0) ^ (d0 + d1));
	expect_store("sll by 3", 16'h001A, d2 << 3);
	expect_store("sra by 5", 16'h001C, {{5{d2[15]}}, d2[15:5]});
	expect_store("ror by 7", 16'h001E, {d2[6:0], d2[15:7]});
	expect_store("pcs", 16'h0020, 16'h0058);
	expect_store("lhb keeps low byte", 16'h0022, {8'h12, d1[7:0]});
	expect_store("llb keeps high byte", 16'h0024, 16'h1234);
	expect_store("b ne not taken", 16'h0026, 16'h0000);
	expect_store("br target", 16'h002A, 16'h007A);
	expect_store("load after store", 16'h002C, 16'h00F4);
endtask

`endif

//--- test/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	localparam cpu_isa_pkg::word_t start_pc = 16'h0020;
	localparam int timeout_cycles = 2000;
	localparam int settle_cycles = 10;
	localparam int mem_words = 256;

	logic clk;
	logic arst_n;
	cpu_isa_pkg::word_t imem_addr;
	cpu_isa_pkg::instr_t imem_data;
	cpu_isa_pkg::word_t dmem_addr;
	cpu_isa_pkg::word_t dmem_wdata;
	logic dmem_wen;
	cpu_isa_pkg::word_t dmem_rdata;
	logic hlt;
	cpu_isa_pkg::word_t pc_out;

	// Both memories are word addressed
	cpu_isa_pkg::instr_t imem [mem_words];
	cpu_isa_pkg::word_t dmem [mem_words];

	// Expected stores in the order they reach memory
	string exp_name [$];
	cpu_isa_pkg::word_t exp_addr [$];
	cpu_isa_pkg::word_t exp_data [$];
	int store_count = 0;

	`include "tb_program.svh"

	// ----------------------------------------
	// Clock and DUT
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever begin
			#20;
			clk = ~clk;
		end
	end

	cpu #(
		.reset_vector(start_pc)
	) UUT (
		.clk(clk),
		.arst_n(arst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_wen(dmem_wen),
		.dmem_rdata(dmem_rdata),
		.hlt(hlt),
		.pc_out(pc_out)
	);

	// ----------------------------------------
	// Memory models
	// ----------------------------------------
	// Reads answer in the same cycle
	assign imem_data = imem[imem_addr[8:1]];
	assign dmem_rdata = dmem[dmem_addr[8:1]];

	always @(posedge clk) begin
		if (dmem_wen) begin
			dmem[dmem_addr[8:1]] <= dmem_wdata;
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input cpu_isa_pkg::word_t expected,
			input cpu_isa_pkg::word_t actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Error: %s data expected %h actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input cpu_isa_pkg::word_t expected,
			input cpu_isa_pkg::word_t actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Error: %s address expected %h actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Error: %s expected %b actual %b",
				name, expected, actual));
		end
	endtask

	task automatic expect_store(input string name, input cpu_isa_pkg::word_t addr,
			input cpu_isa_pkg::word_t data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic fill_memories();
		logic [31:0] state;
		logic [7:0] k;
		state = 32'd19653;
		for (int i = 0; i < mem_words; i++) begin
			k = 8'(i);
			// Stray fetches land on an HLT tagged with its word address
			imem[i] = {4'hF, 4'h0, k};
			dmem[i] = {~k, k};
		end
		for (int i = 0; i < $size(program_words); i++) begin
			k = 8'(i);
			imem[start_pc[8:1] + k] = program_words[i];
		end
		// Operand words 0 to 7
		for (int i = 0; i < 8; i++) begin
			state = lcg_next(state);
			dmem[i] = state[31:16];
		end
	endtask

	// ----------------------------------------
	// Store checker
	// ----------------------------------------
	always @(negedge clk) begin
		if (arst_n && dmem_wen) begin
			if (hlt) begin
				stop_on_error("A store reached memory after the core halted");
			end else if (store_count >= exp_addr.size()) begin
				stop_on_error($sformatf("An extra store to address %h was not expected",
					dmem_addr));
			end else begin
				check_addr(exp_name[store_count], exp_addr[store_count], dmem_addr);
				check_word(exp_name[store_count], exp_data[store_count], dmem_wdata);
				store_count++;
			end
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int wait_cycles;
		arst_n = 1'b0;
		fill_memories();
		load_expected();

		// Reset state after the first edge
		@(negedge clk);
		check_addr("reset vector", start_pc, pc_out);
		check_addr("imem_addr in reset", start_pc, imem_addr);
		check_level("dmem_wen in reset", 1'b0, dmem_wen);
		check_level("hlt in reset", 1'b0, hlt);
		// Four more edges make five reset cycles
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		wait_cycles = 0;
		while (!hlt && (wait_cycles < timeout_cycles)) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!hlt) begin
			stop_on_error($sformatf("Timeout, hlt did not rise within %0d cycles",
				timeout_cycles));
		end

		// Frozen fetch address and held hlt
		for (int i = 0; i < settle_cycles; i++) begin
			@(negedge clk);
			check_addr("pc_out after halt", halt_pc, pc_out);
			check_addr("imem_addr after halt", halt_pc, imem_addr);
			check_level("hlt after halt", 1'b1, hlt);
		end

		if (store_count != exp_addr.size()) begin
			stop_on_error($sformatf("Only %0d of %0d expected stores were seen",
				store_count, exp_addr.size()));
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/register_file.sv
source/alu.sv
source/branch_unit.sv
source/hazard_unit.sv
source/cpu.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - source/cpu_isa_pkg.sv
  - source/cpu_pipe_pkg.sv
  - source/register_file.sv
  - source/alu.sv
  - source/branch_unit.sv
  - source/hazard_unit.sv
  - source/cpu.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cpu_tb.sv
